// File: rtl/dcache_geom_pkg.sv
package dcache_geom_pkg;

	// cache shape: 4 ways of 8 sets, 32-byte lines
	localparam int NUM_SETS = 8;
	localparam int NUM_WAYS = 4;
	localparam int LINE_BYTES = 32;
	localparam int WORDS_PER_LINE = 8;

	// byte address and data word seen by the CPU
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0] strb_t;

	// address fields: tag 31..8, index 7..5, word 4..2
	typedef logic [23:0] tag_t;
	typedef logic [2:0] index_t;
	typedef logic [2:0] word_sel_t;

	// whole line, word 0 sits in the low bits
	typedef logic [LINE_BYTES*8-1:0] line_t;

	typedef logic [1:0] way_t;
	// tree bits: bit0 picks the pair, bit1 and bit2 pick inside a pair
	typedef logic [2:0] plru_t;

endpackage

// File: rtl/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

	// miss handling walks WB_* only for a dirty victim
	typedef enum logic [3:0] {
		IDLE,
		LOOKUP,
		VICTIM,
		WB_REQ,
		WB_DATA,
		FILL_REQ,
		FILL_RECV,
		REFILL,
		WRITE,
		RESP
	} state_t;

	typedef logic [7:0] burst_len_t;
	// len field counts beats minus one
	localparam burst_len_t LINE_BURST_LEN = 8'd7;

	typedef logic [2:0] beat_t;

endpackage

// File: rtl/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic req_valid, req_write,
	input  dcache_geom_pkg::addr_t req_addr,
	input  dcache_geom_pkg::word_t req_wdata,
	input  dcache_geom_pkg::strb_t req_wstrb,
	output logic req_ready, rsp_valid,
	output dcache_geom_pkg::word_t rsp_data,
	input  logic rsp_ready,
	output logic mem_rd_req_valid, mem_rd_rsp_ready,
	output dcache_geom_pkg::addr_t mem_rd_req_addr, mem_wr_req_addr,
	input  logic mem_rd_req_ready, mem_rd_rsp_valid, mem_rd_rsp_last,
	output logic mem_wr_req_valid, mem_wr_data_valid,
	input  logic mem_wr_req_ready, mem_wr_data_ready, mem_wr_data_last,
	// array side
	output dcache_geom_pkg::index_t index,
	output dcache_geom_pkg::tag_t tag,
	output dcache_geom_pkg::word_sel_t word_sel,
	output dcache_geom_pkg::word_t wdata,
	output dcache_geom_pkg::strb_t wstrb,
	output dcache_geom_pkg::way_t sel_way,
	output logic refill_en, write_en, touch_en, wb_load, fill_shift, wb_shift,
	input  logic hit, victim_dirty,
	input  dcache_geom_pkg::way_t hit_way, victim_way,
	input  dcache_geom_pkg::tag_t victim_tag,
	input  dcache_geom_pkg::word_t rd_word, fill_word
);

	dcache_ctrl_pkg::state_t state_q, state_d;
	dcache_geom_pkg::addr_t addr_q, wb_addr_q;
	dcache_geom_pkg::way_t way_q;
	logic write_q, lookup_en, victim_en;

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= dcache_ctrl_pkg::IDLE;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			dcache_ctrl_pkg::IDLE: if (req_valid) state_d = dcache_ctrl_pkg::LOOKUP;
			dcache_ctrl_pkg::LOOKUP:
				if (!hit)
					state_d = dcache_ctrl_pkg::VICTIM;
				else
					state_d = write_q ? dcache_ctrl_pkg::WRITE : dcache_ctrl_pkg::RESP;
			// clean victim is simply overwritten
			dcache_ctrl_pkg::VICTIM:
				state_d = victim_dirty ? dcache_ctrl_pkg::WB_REQ : dcache_ctrl_pkg::FILL_REQ;
			dcache_ctrl_pkg::WB_REQ: if (mem_wr_req_ready) state_d = dcache_ctrl_pkg::WB_DATA;
			dcache_ctrl_pkg::WB_DATA:
				if (mem_wr_data_ready && mem_wr_data_last)
					state_d = dcache_ctrl_pkg::FILL_REQ;
			dcache_ctrl_pkg::FILL_REQ: if (mem_rd_req_ready) state_d = dcache_ctrl_pkg::FILL_RECV;
			dcache_ctrl_pkg::FILL_RECV:
				if (mem_rd_rsp_valid && mem_rd_rsp_last)
					state_d = dcache_ctrl_pkg::REFILL;
			// a write miss merges into the fresh line afterwards
			dcache_ctrl_pkg::REFILL:
				state_d = write_q ? dcache_ctrl_pkg::WRITE : dcache_ctrl_pkg::RESP;
			dcache_ctrl_pkg::WRITE: state_d = dcache_ctrl_pkg::IDLE;
			dcache_ctrl_pkg::RESP: if (rsp_ready) state_d = dcache_ctrl_pkg::IDLE;
			default: state_d = dcache_ctrl_pkg::IDLE;
		endcase
	end

	assign lookup_en = state_q == dcache_ctrl_pkg::LOOKUP;
	assign victim_en = state_q == dcache_ctrl_pkg::VICTIM;

	// request, way and response registers
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			write_q <= req_write;
			addr_q <= req_addr;
			wdata <= req_wdata;
			wstrb <= req_wstrb;
		end
		if (lookup_en)
			way_q <= hit_way;
		if (victim_en) begin
			way_q <= victim_way;
			wb_addr_q <= {victim_tag, index, 5'b0};
		end
		if (lookup_en && hit && !write_q)
			rsp_data <= rd_word;
		else if (state_q == dcache_ctrl_pkg::REFILL && !write_q)
			rsp_data <= fill_word;
	end

	assign index = addr_q[7:5];
	assign tag = addr_q[31:8];
	assign word_sel = addr_q[4:2];
	// arrays see the chosen way in the same cycle it is decided
	assign sel_way = lookup_en ? hit_way : (victim_en ? victim_way : way_q);
	assign mem_rd_req_addr = {addr_q[31:5], 5'b0};
	assign mem_wr_req_addr = wb_addr_q;

	// handshakes and array strobes follow the state directly
	assign req_ready = state_q == dcache_ctrl_pkg::IDLE;
	assign rsp_valid = state_q == dcache_ctrl_pkg::RESP;
	assign mem_wr_req_valid = state_q == dcache_ctrl_pkg::WB_REQ;
	assign mem_wr_data_valid = state_q == dcache_ctrl_pkg::WB_DATA;
	assign mem_rd_req_valid = state_q == dcache_ctrl_pkg::FILL_REQ;
	assign mem_rd_rsp_ready = state_q == dcache_ctrl_pkg::FILL_RECV;
	assign wb_load = victim_en && victim_dirty;
	assign wb_shift = mem_wr_data_valid && mem_wr_data_ready;
	assign fill_shift = mem_rd_rsp_ready && mem_rd_rsp_valid;
	assign refill_en = state_q == dcache_ctrl_pkg::REFILL;
	assign write_en = state_q == dcache_ctrl_pkg::WRITE;
	assign touch_en = write_en || (rsp_valid && rsp_ready);

	// a pending response holds its data until the CPU takes it
	a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

// File: rtl/dcache_tag_array.sv
`timescale 1ns/10ps

module dcache_tag_array (
	input  logic clk,
	input  logic rst,
	input  dcache_geom_pkg::index_t index,
	input  dcache_geom_pkg::tag_t tag,
	input  dcache_geom_pkg::way_t sel_way,
	input  dcache_geom_pkg::way_t victim_way,
	input  logic refill_en,
	input  logic write_en,
	output logic hit,
	output dcache_geom_pkg::way_t hit_way,
	output logic [dcache_geom_pkg::NUM_WAYS-1:0] valid_vec,
	output logic victim_dirty,
	output dcache_geom_pkg::tag_t victim_tag
);

	logic [dcache_geom_pkg::NUM_WAYS-1:0] valid_q [dcache_geom_pkg::NUM_SETS];
	logic [dcache_geom_pkg::NUM_WAYS-1:0] dirty_q [dcache_geom_pkg::NUM_SETS];
	dcache_geom_pkg::tag_t tag_q [dcache_geom_pkg::NUM_SETS][dcache_geom_pkg::NUM_WAYS];
	logic [dcache_geom_pkg::NUM_WAYS-1:0] hit_vec;

	// all four ways compared at once
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < dcache_geom_pkg::NUM_WAYS; w++) begin
			hit_vec[w] = valid_q[index][w] && (tag_q[index][w] == tag);
			if (hit_vec[w])
				hit_way = dcache_geom_pkg::way_t'(w);
		end
	end

	assign hit = |hit_vec;
	assign valid_vec = valid_q[index];
	// only a valid line can need a write-back
	assign victim_dirty = valid_q[index][victim_way] && dirty_q[index][victim_way];
	assign victim_tag = tag_q[index][victim_way];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < dcache_geom_pkg::NUM_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else if (refill_en) begin
			valid_q[index][sel_way] <= 1'b1;
			dirty_q[index][sel_way] <= 1'b0;
		end else if (write_en) begin
			dirty_q[index][sel_way] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (refill_en)
			tag_q[index][sel_way] <= tag;
	end

	// a refill only ever installs a tag that missed
	a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

endmodule

// File: rtl/dcache_plru.sv
`timescale 1ns/10ps

module dcache_plru (
	input  logic clk,
	input  logic rst,
	input  dcache_geom_pkg::index_t index,
	input  logic [dcache_geom_pkg::NUM_WAYS-1:0] valid_vec,
	input  logic touch_en,
	input  dcache_geom_pkg::way_t sel_way,
	output dcache_geom_pkg::way_t victim_way
);

	dcache_geom_pkg::plru_t plru_q [dcache_geom_pkg::NUM_SETS];
	dcache_geom_pkg::plru_t cur;

	assign cur = plru_q[index];

	// empty ways fill first, lowest number wins
	always_comb begin
		if (!valid_vec[0])
			victim_way = 2'd0;
		else if (!valid_vec[1])
			victim_way = 2'd1;
		else if (!valid_vec[2])
			victim_way = 2'd2;
		else if (!valid_vec[3])
			victim_way = 2'd3;
		else if (!cur[0])
			victim_way = cur[1] ? 2'd1 : 2'd0;
		else
			victim_way = cur[2] ? 2'd3 : 2'd2;
	end

	// point the tree away from the way just used
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < dcache_geom_pkg::NUM_SETS; s++)
				plru_q[s] <= '0;
		end else if (touch_en) begin
			plru_q[index][0] <= !sel_way[1];
			if (!sel_way[1])
				plru_q[index][1] <= sel_way == 2'd0;
			else
				plru_q[index][2] <= sel_way == 2'd2;
		end
	end

endmodule

// File: rtl/dcache_data_array.sv
`timescale 1ns/10ps

module dcache_data_array (
	input  logic clk,
	input  dcache_geom_pkg::index_t index,
	input  dcache_geom_pkg::word_sel_t word_sel,
	input  dcache_geom_pkg::way_t sel_way,
	input  dcache_geom_pkg::word_t wdata,
	input  dcache_geom_pkg::strb_t wstrb,
	input  logic write_en,
	input  logic refill_en,
	input  dcache_geom_pkg::line_t fill_line,
	output dcache_geom_pkg::word_t rd_word,
	output dcache_geom_pkg::line_t rd_line
);

	dcache_geom_pkg::line_t mem_q [dcache_geom_pkg::NUM_SETS][dcache_geom_pkg::NUM_WAYS];

	// read path is purely combinational
	assign rd_line = mem_q[index][sel_way];
	assign rd_word = rd_line[{word_sel, 5'b0} +: 32];

	always_ff @(posedge clk) begin
		if (refill_en) begin
			mem_q[index][sel_way] <= fill_line;
		end else if (write_en) begin
			// untouched bytes keep their old value
			for (int b = 0; b < 4; b++) begin
				if (wstrb[b])
					mem_q[index][sel_way][{word_sel, 5'b0} + b*8 +: 8] <= wdata[b*8 +: 8];
			end
		end
	end

endmodule

// File: rtl/dcache_line_buffer.sv
`timescale 1ns/10ps

module dcache_line_buffer (
	input  logic clk,
	input  logic rst,
	input  dcache_geom_pkg::word_sel_t word_sel,
	input  logic fill_shift,
	input  dcache_geom_pkg::word_t mem_rd_rsp_data,
	input  logic wb_load,
	input  logic wb_shift,
	input  dcache_geom_pkg::line_t rd_line,
	output dcache_geom_pkg::line_t fill_line,
	output dcache_geom_pkg::word_t fill_word,
	output dcache_geom_pkg::word_t wb_word,
	output logic wb_last
);

	dcache_geom_pkg::line_t wb_line;
	dcache_ctrl_pkg::beat_t beat_q;
	// set once all eight victim words have left
	logic wb_done;

	// refill beats enter at the top, so beat 0 ends up in word 0
	always_ff @(posedge clk) begin
		if (fill_shift)
			fill_line <= {mem_rd_rsp_data, fill_line[$bits(fill_line)-1:32]};
		if (wb_load)
			wb_line <= rd_line;
		else if (wb_shift)
			wb_line <= {32'b0, wb_line[$bits(wb_line)-1:32]};
	end

	always_ff @(posedge clk) begin
		if (rst || wb_load) begin
			beat_q <= '0;
			wb_done <= 1'b0;
		end else if (wb_shift) begin
			beat_q <= beat_q + 1'b1;
			wb_done <= wb_last;
		end
	end

	assign fill_word = fill_line[{word_sel, 5'b0} +: 32];
	assign wb_word = wb_line[31:0];
	assign wb_last = beat_q == dcache_ctrl_pkg::beat_t'(dcache_geom_pkg::WORDS_PER_LINE - 1);

	// the controller must leave WB_DATA on the last beat
	a_no_overrun: assert property (@(posedge clk) disable iff (rst) !(wb_shift && wb_done));

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/10ps

module dcache_top (
	input  logic clk,
	input  logic rst,
	// CPU request and response
	input  logic req_valid,
	input  logic req_write,
	input  dcache_geom_pkg::addr_t req_addr,
	input  dcache_geom_pkg::word_t req_wdata,
	input  dcache_geom_pkg::strb_t req_wstrb,
	output logic req_ready,
	output logic rsp_valid,
	output dcache_geom_pkg::word_t rsp_data,
	input  logic rsp_ready,
	// memory read channels
	output logic mem_rd_req_valid,
	output dcache_geom_pkg::addr_t mem_rd_req_addr,
	output dcache_ctrl_pkg::burst_len_t mem_rd_req_len,
	input  logic mem_rd_req_ready,
	input  logic mem_rd_rsp_valid,
	input  dcache_geom_pkg::word_t mem_rd_rsp_data,
	input  logic mem_rd_rsp_last,
	output logic mem_rd_rsp_ready,
	// memory write channels
	output logic mem_wr_req_valid,
	output dcache_geom_pkg::addr_t mem_wr_req_addr,
	output dcache_ctrl_pkg::burst_len_t mem_wr_req_len,
	input  logic mem_wr_req_ready,
	output logic mem_wr_data_valid,
	output dcache_geom_pkg::word_t mem_wr_data,
	output dcache_geom_pkg::strb_t mem_wr_data_strb,
	output logic mem_wr_data_last,
	input  logic mem_wr_data_ready
);

	dcache_geom_pkg::index_t index;
	dcache_geom_pkg::tag_t tag, victim_tag;
	dcache_geom_pkg::word_sel_t word_sel;
	dcache_geom_pkg::word_t wdata, rd_word, fill_word;
	dcache_geom_pkg::strb_t wstrb;
	dcache_geom_pkg::way_t sel_way, hit_way, victim_way;
	dcache_geom_pkg::line_t rd_line, fill_line;
	logic [dcache_geom_pkg::NUM_WAYS-1:0] valid_vec;
	logic refill_en, write_en, touch_en, wb_load, fill_shift, wb_shift;
	logic hit, victim_dirty;

	// every transfer to memory is a full line burst
	assign mem_rd_req_len = dcache_ctrl_pkg::LINE_BURST_LEN;
	assign mem_wr_req_len = dcache_ctrl_pkg::LINE_BURST_LEN;
	assign mem_wr_data_strb = '1;

	dcache_ctrl u_ctrl (.*);
	dcache_tag_array u_tag (.*);
	dcache_plru u_plru (.*);
	dcache_data_array u_data (.*);

	// victim words go straight onto the write data channel
	dcache_line_buffer u_lbuf (
		.clk(clk), .rst(rst), .word_sel(word_sel),
		.fill_shift(fill_shift), .mem_rd_rsp_data(mem_rd_rsp_data),
		.wb_load(wb_load), .wb_shift(wb_shift), .rd_line(rd_line),
		.fill_line(fill_line), .fill_word(fill_word),
		.wb_word(mem_wr_data), .wb_last(mem_wr_data_last)
	);

endmodule

// File: bench/mem_model.sv
`timescale 1ns/10ps

module mem_model (
	input  logic clk,
	input  logic rst,
	input  logic mem_rd_req_valid,
	input  dcache_geom_pkg::addr_t mem_rd_req_addr,
	input  dcache_ctrl_pkg::burst_len_t mem_rd_req_len,
	output logic mem_rd_req_ready,
	output logic mem_rd_rsp_valid,
	output dcache_geom_pkg::word_t mem_rd_rsp_data,
	output logic mem_rd_rsp_last,
	input  logic mem_rd_rsp_ready,
	input  logic mem_wr_req_valid,
	input  dcache_geom_pkg::addr_t mem_wr_req_addr,
	input  dcache_ctrl_pkg::burst_len_t mem_wr_req_len,
	output logic mem_wr_req_ready,
	input  logic mem_wr_data_valid,
	input  dcache_geom_pkg::word_t mem_wr_data,
	input  dcache_geom_pkg::strb_t mem_wr_data_strb,
	input  logic mem_wr_data_last,
	output logic mem_wr_data_ready,
	// burst log seen by the testbench
	output int rd_count,
	output dcache_geom_pkg::addr_t rd_last_addr,
	output dcache_ctrl_pkg::burst_len_t rd_last_len,
	output int wb_count,
	output dcache_geom_pkg::addr_t wb_last_addr,
	output dcache_ctrl_pkg::burst_len_t wb_last_len,
	output dcache_geom_pkg::line_t wb_line,
	output dcache_geom_pkg::strb_t wb_strb_all,
	output int wb_beats,
	output int wb_last_pos
);

	dcache_geom_pkg::word_t mem [dcache_geom_pkg::addr_t];
	logic [31:0] rnd_q;
	logic rd_busy, wr_busy;
	dcache_geom_pkg::addr_t rd_addr, wr_addr;
	dcache_ctrl_pkg::burst_len_t rd_len;
	int rd_beat, wr_beat;
	dcache_geom_pkg::word_t merged;

	// untouched words hold a value spread over the whole address
	function automatic dcache_geom_pkg::word_t pattern_word(dcache_geom_pkg::addr_t a);
		return (a * 32'h9E37_79B1) ^ 32'h1357_2468;
	endfunction

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic dcache_geom_pkg::word_t read_word(dcache_geom_pkg::addr_t a);
		return mem.exists(a) ? mem[a] : pattern_word(a);
	endfunction

	// each ready stalls about half the time
	assign mem_rd_req_ready = rnd_q[0] && !rd_busy;
	assign mem_wr_req_ready = rnd_q[1] && !wr_busy;
	assign mem_wr_data_ready = rnd_q[2] && wr_busy;

	always @(posedge clk) begin
		if (rst) begin
			rnd_q <= 32'd39;
			rd_busy <= 1'b0;
			wr_busy <= 1'b0;
			mem_rd_rsp_valid <= 1'b0;
			rd_count <= 0;
			wb_count <= 0;
		end else begin
			rnd_q <= xorshift32(rnd_q);
			if (mem_rd_req_valid && mem_rd_req_ready) begin
				rd_busy <= 1'b1;
				rd_addr <= mem_rd_req_addr;
				rd_len <= mem_rd_req_len;
				rd_beat <= 0;
				rd_count <= rd_count + 1;
				rd_last_addr <= mem_rd_req_addr;
				rd_last_len <= mem_rd_req_len;
			end
			// a presented beat stays put until it is taken
			if (mem_rd_rsp_valid && mem_rd_rsp_ready) begin
				mem_rd_rsp_valid <= 1'b0;
				rd_beat <= rd_beat + 1;
				if (mem_rd_rsp_last)
					rd_busy <= 1'b0;
			end else if (rd_busy && !mem_rd_rsp_valid && rnd_q[3]) begin
				mem_rd_rsp_valid <= 1'b1;
				mem_rd_rsp_data <= read_word(rd_addr + 4 * rd_beat);
				mem_rd_rsp_last <= rd_beat == int'(rd_len);
			end
			if (mem_wr_req_valid && mem_wr_req_ready) begin
				wr_busy <= 1'b1;
				wr_addr <= mem_wr_req_addr;
				wr_beat <= 0;
				wb_count <= wb_count + 1;
				wb_last_addr <= mem_wr_req_addr;
				wb_last_len <= mem_wr_req_len;
				wb_strb_all <= '1;
				wb_beats <= 0;
				wb_last_pos <= -1;
			end
			// write beats land in memory and in the log
			if (mem_wr_data_valid && mem_wr_data_ready) begin
				merged = read_word(wr_addr + 4 * wr_beat);
				for (int b = 0; b < 4; b++) begin
					if (mem_wr_data_strb[b])
						merged[b*8 +: 8] = mem_wr_data[b*8 +: 8];
				end
				mem[wr_addr + 4 * wr_beat] = merged;
				wb_line[wr_beat*32 +: 32] <= mem_wr_data;
				wb_strb_all <= wb_strb_all & mem_wr_data_strb;
				wb_beats <= wb_beats + 1;
				wr_beat <= wr_beat + 1;
				if (mem_wr_data_last) begin
					wr_busy <= 1'b0;
					wb_last_pos <= wr_beat;
				end
			end
		end
	end

endmodule

// File: bench/tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache;

	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DELAY = 1;
	// worst case per access is two stalled 8-beat bursts plus a held response
	localparam int ACCESS_BUDGET = 70;
	localparam int CYCLES_PER_ACCESS = 150;
	localparam int WATCHDOG_NS = ACCESS_BUDGET * CYCLES_PER_ACCESS * CLK_PERIOD;

	logic clk = 1'b0;
	logic rst;
	logic req_valid, req_write, req_ready, rsp_valid, rsp_ready;
	dcache_geom_pkg::addr_t req_addr, mem_rd_req_addr, mem_wr_req_addr;
	dcache_geom_pkg::word_t req_wdata, rsp_data, mem_rd_rsp_data, mem_wr_data;
	dcache_geom_pkg::strb_t req_wstrb, mem_wr_data_strb, wb_strb_all;
	dcache_ctrl_pkg::burst_len_t mem_rd_req_len, mem_wr_req_len, rd_last_len, wb_last_len;
	logic mem_rd_req_valid, mem_rd_req_ready, mem_rd_rsp_valid, mem_rd_rsp_last;
	logic mem_rd_rsp_ready, mem_wr_req_valid, mem_wr_req_ready;
	logic mem_wr_data_valid, mem_wr_data_last, mem_wr_data_ready;
	int rd_count, wb_count, wb_beats, wb_last_pos;
	dcache_geom_pkg::addr_t rd_last_addr, wb_last_addr;
	dcache_geom_pkg::line_t wb_line;

	// CPU view of memory, keyed by word address
	dcache_geom_pkg::word_t ref_mem [dcache_geom_pkg::addr_t];
	int err_count = 0;
	int check_count = 0;
	int test_count = 0;
	logic [31:0] rng_state = 32'd39;

	dcache_top UUT (.*);
	mem_model u_mem (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic dcache_geom_pkg::word_t pattern_word(dcache_geom_pkg::addr_t a);
		return (a * 32'h9E37_79B1) ^ 32'h1357_2468;
	endfunction

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic dcache_geom_pkg::word_t ref_read(dcache_geom_pkg::addr_t a);
		dcache_geom_pkg::addr_t wa;
		wa = {a[31:2], 2'b00};
		return ref_mem.exists(wa) ? ref_mem[wa] : pattern_word(wa);
	endfunction

	task automatic ref_write(dcache_geom_pkg::addr_t a, dcache_geom_pkg::word_t d,
			dcache_geom_pkg::strb_t s);
		dcache_geom_pkg::word_t w;
		w = ref_read(a);
		for (int b = 0; b < 4; b++) begin
			if (s[b])
				w[b*8 +: 8] = d[b*8 +: 8];
		end
		ref_mem[{a[31:2], 2'b00}] = w;
	endtask

	// tree model: bit0 picks the pair, bit1/bit2 the way inside it
	function automatic logic [2:0] plru_touch(logic [2:0] t, int way);
		if (way < 2) begin
			t[0] = 1'b1;
			t[1] = way == 0;
		end else begin
			t[0] = 1'b0;
			t[2] = way == 2;
		end
		return t;
	endfunction

	function automatic int plru_victim(logic [2:0] t);
		if (!t[0])
			return t[1] ? 1 : 0;
		return t[2] ? 3 : 2;
	endfunction

	task automatic check_word(string name, dcache_geom_pkg::word_t got, dcache_geom_pkg::word_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(string name, dcache_geom_pkg::addr_t got, dcache_geom_pkg::addr_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count_val(string name, int got, int exp);
		check_count++;
		if (got != exp) begin
			err_count++;
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic report_test(string name, int errs_before);
		test_count++;
		$display("test %s: %s", name, err_count == errs_before ? "ok" : "FAILED");
	endtask

	// all driving happens a short delay after the rising edge
	task automatic tick();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// lat counts edges from acceptance to the edge that sees the done signal
	task automatic cpu_access(input bit wr, input dcache_geom_pkg::addr_t a,
			input dcache_geom_pkg::word_t d, input dcache_geom_pkg::strb_t s,
			input int hold, output int lat);
		dcache_geom_pkg::word_t first;
		req_valid = 1'b1;
		req_write = wr;
		req_addr = a;
		req_wdata = d;
		req_wstrb = s;
		while (!req_ready)
			tick();
		tick();
		req_valid = 1'b0;
		lat = 1;
		if (wr) begin
			while (!req_ready) begin
				tick();
				lat++;
			end
			ref_write(a, d, s);
		end else begin
			while (!rsp_valid) begin
				tick();
				lat++;
			end
			first = rsp_data;
			// response must stay put while the CPU stalls
			repeat (hold) begin
				tick();
				check_bit("rsp_valid", rsp_valid, 1'b1);
				check_word("rsp_data", rsp_data, first);
			end
			check_word("rsp_data", first, ref_read(a));
			rsp_ready = 1'b1;
			tick();
			rsp_ready = 1'b0;
		end
	endtask

	task automatic test_reset_read_miss();
		int errs0, lat;
		errs0 = err_count;
		check_bit("req_ready", req_ready, 1'b1);
		check_bit("rsp_valid", rsp_valid, 1'b0);
		check_bit("mem_rd_req_valid", mem_rd_req_valid, 1'b0);
		check_bit("mem_wr_req_valid", mem_wr_req_valid, 1'b0);
		check_bit("mem_wr_data_valid", mem_wr_data_valid, 1'b0);
		check_bit("mem_rd_rsp_ready", mem_rd_rsp_ready, 1'b0);
		cpu_access(1'b0, 32'h0000_1234, '0, '0, 0, lat);
		check_count_val("rd_count", rd_count, 1);
		check_addr("mem_rd_req_addr", rd_last_addr, 32'h0000_1220);
		check_count_val("mem_rd_req_len", int'(rd_last_len), int'(dcache_ctrl_pkg::LINE_BURST_LEN));
		report_test("reset_read_miss", errs0);
	endtask

	task automatic test_write_hit_merge();
		int errs0, lat, rd0, wb0;
		errs0 = err_count;
		rd0 = rd_count;
		wb0 = wb_count;
		cpu_access(1'b1, 32'h0000_1234, 32'hDEAD_BEEF, 4'b0101, 0, lat);
		check_count_val("write hit latency", lat, 3);
		cpu_access(1'b0, 32'h0000_1234, '0, '0, 0, lat);
		check_count_val("read hit latency", lat, 2);
		check_count_val("rd_count", rd_count, rd0);
		check_count_val("wb_count", wb_count, wb0);
		report_test("write_hit_merge", errs0);
	endtask

	task automatic test_write_miss_allocate();
		int errs0, lat, rd0;
		errs0 = err_count;
		rd0 = rd_count;
		cpu_access(1'b1, 32'h0000_2468, 32'h1234_5678, 4'b1110, 0, lat);
		check_count_val("rd_count", rd_count, rd0 + 1);
		check_addr("mem_rd_req_addr", rd_last_addr, 32'h0000_2460);
		cpu_access(1'b0, 32'h0000_2468, '0, '0, 0, lat);
		check_count_val("rd_count", rd_count, rd0 + 1);
		report_test("write_miss_allocate", errs0);
	endtask

	task automatic test_plru_victim();
		int errs0, lat, victim, wb0;
		int order [4];
		dcache_geom_pkg::addr_t line_a [5];
		logic [2:0] tree;
		errs0 = err_count;
		tree = '0;
		order = '{3, 0, 2, 1};
		// five tags that all map to set 5
		for (int i = 0; i < 5; i++)
			line_a[i] = 32'h0001_00A0 + i * 256;
		// empty set fills ways 0..3 in order
		for (int i = 0; i < 4; i++) begin
			cpu_access(1'b1, line_a[i], 32'hA000_0000 | i, 4'hF, 0, lat);
			tree = plru_touch(tree, i);
		end
		for (int i = 0; i < 4; i++) begin
			cpu_access(1'b1, line_a[order[i]] + 4 * (i + 1), 32'hB000_0000 | order[i], 4'hF, 0, lat);
			tree = plru_touch(tree, order[i]);
		end
		victim = plru_victim(tree);
		wb0 = wb_count;
		cpu_access(1'b0, line_a[4], '0, '0, 0, lat);
		check_count_val("wb_count", wb_count, wb0 + 1);
		check_addr("mem_wr_req_addr", wb_last_addr, line_a[victim]);
		check_count_val("mem_wr_req_len", int'(wb_last_len), int'(dcache_ctrl_pkg::LINE_BURST_LEN));
		check_count_val("write-back beats", wb_beats, 8);
		check_count_val("mem_wr_data_last beat", wb_last_pos, 7);
		check_count_val("mem_wr_data_strb", int'(wb_strb_all), 15);
		for (int i = 0; i < 8; i++)
			check_word("mem_wr_data", wb_line[i*32 +: 32], ref_read(line_a[victim] + 4 * i));
		report_test("plru_victim", errs0);
	endtask

	task automatic test_random_traffic();
		int errs0, lat;
		logic [31:0] r;
		dcache_geom_pkg::addr_t a;
		errs0 = err_count;
		// long CPU stall on a response that needs a refill first
		cpu_access(1'b0, 32'h0000_05C8, '0, '0, 6, lat);
		// eight tags over sets 2 and 6 force evictions
		for (int i = 0; i < 40; i++) begin
			rng_state = xorshift32(rng_state);
			r = rng_state;
			rng_state = xorshift32(rng_state);
			a = {24'h000300 | r[2:0], r[3] ? 3'd2 : 3'd6, r[6:4], 2'b00};
			cpu_access(r[7], a, rng_state, r[11:8], int'(r[13:12]), lat);
		end
		report_test("random_traffic", errs0);
	endtask

	initial begin
		#WATCHDOG_NS;
		$display("timeout after %0d ns, the DUT stopped responding", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_wstrb = '0;
		rsp_ready = 1'b0;
		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		test_reset_read_miss();
		test_write_hit_merge();
		test_write_miss_allocate();
		test_plru_victim();
		test_random_traffic();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: dcache.f
rtl/dcache_geom_pkg.sv
rtl/dcache_ctrl_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_tag_array.sv
rtl/dcache_plru.sv
rtl/dcache_data_array.sv
rtl/dcache_line_buffer.sv
rtl/dcache_top.sv
bench/mem_model.sv
bench/tb_dcache.sv
